// File: src.f
+incdir+.
phy_init_pkg.sv
init_delay_timer.sv
phy_init_fsm.sv
mdio_master.sv
phy_init_top.sv
tb_phy_init.sv

// File: tb_phy_init.sv
// testbench that drives reset into phy_init_top and checks the decoded MDIO write frames
`timescale 1ns/1ps
`include "phy_init_settings.svh"

module tb_phy_init;

    localparam int INIT_DELAY   = 100;
    localparam int FRAME_CYCLES = 64 * 2 * `MDC_HALF_PERIOD + 16;
    localparam int RUN_CYCLES   = INIT_DELAY + `INIT_STEPS * FRAME_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 8 * FRAME_CYCLES;

    logic clk_125mhz;
    logic rst_125mhz;
    logic phy_mdc, phy_mdio_o, phy_mdio_t, phy_reset_n, init_done;

    logic [63:0] shift_bits;
    logic        mdc_prev, mdio_t_prev, init_done_prev;
    logic [63:0] frame_q[$];
    int          idx_q[$];
    int          bit_count, frame_idx, checked_frames;
    int          value_errors, protocol_errors, reset_point;
    logic [31:0] rand_state;

    phy_init_top #(.init_delay_cycles(INIT_DELAY)) u_dut (
        .clk_125mhz  (clk_125mhz),
        .rst_125mhz  (rst_125mhz),
        .phy_mdc     (phy_mdc),
        .phy_mdio_o  (phy_mdio_o),
        .phy_mdio_t  (phy_mdio_t),
        .phy_reset_n (phy_reset_n),
        .init_done   (init_done)
    );

    always #4 clk_125mhz = ~clk_125mhz;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected command word for one step of the REGCR and ADDAR write groups
    function automatic logic [31:0] expected_cmd(input int step);
        logic [15:0] target;
        logic [15:0] value;
        logic [15:0] data;
        logic [4:0]  reg_addr;
        case (step / 4)
            0: begin
                target = 16'h0031;
                value  = 16'h0070;
            end
            1: begin
                target = 16'h00D3;
                value  = 16'h4000;
            end
            default: begin
                target = 16'h016F;
                value  = 16'h0015;
            end
        endcase
        // even steps write REGCR, odd steps ADDAR
        reg_addr = (step % 2 == 0) ? 5'h0D : 5'h0E;
        case (step % 4)
            0:       data = 16'h001F;
            1:       data = target;
            2:       data = 16'h401F;
            default: data = value;
        endcase
        return {2'b01, 2'b01, 5'd3, reg_addr, 2'b10, data};
    endfunction

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("[ERROR] %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        value_errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("protocol error at %0t: %s", $time, msg);
        protocol_errors++;
    endtask

    // mdc held low and mdio released
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk_125mhz);
            assert (phy_mdc == 1'b0) else value_error("phy_mdc", phy_mdc, 0);
            assert (phy_mdio_t == 1'b1) else value_error("phy_mdio_t", phy_mdio_t, 1);
        end
    endtask

    task automatic hold_reset();
        repeat (14) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        assert (phy_mdio_o == 1'b1) else value_error("phy_mdio_o", phy_mdio_o, 1);
        assert (init_done == 1'b0) else value_error("init_done", init_done, 0);
        check_quiet(1);
        @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;
    endtask

    // frame decoder on the falling clock edge where the MDIO outputs are steady
    always @(negedge clk_125mhz) begin
        assert (phy_reset_n == !rst_125mhz)
            else value_error("phy_reset_n", phy_reset_n, !rst_125mhz);
        if (rst_125mhz) begin
            bit_count = 0;
            frame_idx = 0;
        end else begin
            if (phy_mdc && !mdc_prev) begin
                assert (!phy_mdio_t) else protocol_error("MDC rising edge while MDIO is released");
                shift_bits = {shift_bits[62:0], phy_mdio_o};
                bit_count++;
            end
            if (phy_mdio_t && !mdio_t_prev) begin
                assert (bit_count == 64) else value_error("phy_mdio_t low bits", bit_count, 64);
                assert (!init_done) else protocol_error("init_done high before a frame ended");
                frame_q.push_back(shift_bits);
                idx_q.push_back(frame_idx);
                frame_idx++;
                bit_count = 0;
            end
            if (init_done) begin
                assert (frame_idx == 12) else protocol_error("init_done high without twelve frames");
            end
            assert (!(init_done_prev && !init_done)) else protocol_error("init_done dropped");
        end
        mdc_prev       = phy_mdc;
        mdio_t_prev    = phy_mdio_t;
        init_done_prev = init_done;
    end

    always @(negedge clk_125mhz) begin : compare_frames
        logic [63:0] frame;
        int          idx;
        while (frame_q.size() > 0) begin
            frame = frame_q.pop_front();
            idx   = idx_q.pop_front();
            checked_frames++;
            assert (frame[63:32] == 32'hFFFF_FFFF)
                else value_error("phy_mdio_o preamble", frame[63:32], 32'hFFFF_FFFF);
            assert (frame[31:30] == 2'b01)
                else value_error("phy_mdio_o st", frame[31:30], 2'b01);
            assert (frame[29:28] == 2'b01)
                else value_error("phy_mdio_o op", frame[29:28], 2'b01);
            assert (frame[27:23] == 5'd3)
                else value_error("phy_mdio_o phy_addr", frame[27:23], 3);
            assert (frame[17:16] == 2'b10)
                else value_error("phy_mdio_o ta", frame[17:16], 2'b10);
            assert (idx < 12) else protocol_error("frame sent after the end of the sequence");
            if (idx < 12) begin
                assert (frame[31:0] == expected_cmd(idx))
                    else value_error($sformatf("phy_mdio_o frame %0d", idx), frame[31:0],
                                     expected_cmd(idx));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_125mhz);
        $display("watchdog expired before the init sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk_125mhz = 1'b0;
        rst_125mhz = 1'b1;
        mdc_prev = 1'b0;
        mdio_t_prev = 1'b1;
        init_done_prev = 1'b0;
        shift_bits = 64'd0;
        value_errors = 0;
        protocol_errors = 0;
        checked_frames = 0;
        rand_state = xorshift32(32'd33237);
        reset_point = 600 + int'(rand_state % 3000);
        hold_reset();
        check_quiet(INIT_DELAY);
        // interrupt the first run partway through
        repeat (reset_point) @(posedge clk_125mhz);
        assert (!init_done) else protocol_error("sequence finished before the reset point");
        rst_125mhz <= 1'b1;
        hold_reset();
        check_quiet(INIT_DELAY);
        while (!init_done) @(negedge clk_125mhz);
        check_quiet(2 * FRAME_CYCLES);
        assert (frame_idx == 12) else protocol_error("wrong number of frames after the restart");
        $display("frames compared %0d, value errors %0d, protocol errors %0d",
                 checked_frames, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: phy_init_top.sv
// top level of the PHY start-up block, runs the MDIO register sequence after reset
`timescale 1ns/1ps
`include "phy_init_settings.svh"

module phy_init_top
    import phy_init_pkg::*;
#(
    // power-up hold-off in clk_125mhz cycles, short values for simulation
    parameter int init_delay_cycles = `INIT_DELAY_DEFAULT
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    output logic phy_mdc,
    output logic phy_mdio_o,
    output logic phy_mdio_t,
    output logic phy_reset_n,
    output logic init_done
);

    logic      delay_start;
    logic      delay_expired;
    mdio_cmd_t mdio_cmd;
    logic      mdio_cmd_valid;
    logic      mdio_cmd_ready;
    logic      mdio_idle;

    // PHY held in reset along with the FPGA logic
    assign phy_reset_n = !rst_125mhz;

    init_delay_timer u_timer (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .load_value (20'(init_delay_cycles)),
        .start      (delay_start),
        .expired    (delay_expired)
    );

    phy_init_fsm u_fsm (
        .clk_125mhz    (clk_125mhz),
        .rst_125mhz    (rst_125mhz),
        .delay_start   (delay_start),
        .delay_expired (delay_expired),
        .cmd           (mdio_cmd),
        .cmd_valid     (mdio_cmd_valid),
        .cmd_ready     (mdio_cmd_ready),
        .master_idle   (mdio_idle),
        .init_done     (init_done)
    );

    mdio_master u_mdio (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .cmd        (mdio_cmd),
        .cmd_valid  (mdio_cmd_valid),
        .cmd_ready  (mdio_cmd_ready),
        .idle       (mdio_idle),
        .mdc        (phy_mdc),
        .mdio_o     (phy_mdio_o),
        .mdio_t     (phy_mdio_t)
    );

endmodule

// File: mdio_master.sv
// clause-22 MDIO write master, generates MDC and shifts preamble and command out on mdio_o
`timescale 1ns/1ps
`include "phy_init_settings.svh"

module mdio_master
    import phy_init_pkg::*;
(
    input  logic      clk_125mhz,
    input  logic      rst_125mhz,
    input  mdio_cmd_t cmd,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    output logic      idle,
    output logic      mdc,
    output logic      mdio_o,
    output logic      mdio_t
);

    localparam int FRAME_BITS = `MDIO_PREAMBLE_BITS + $bits(mdio_cmd_t);

    localparam logic [7:0] HALF_LOAD = 8'(`MDC_HALF_PERIOD - 1);
    localparam logic [5:0] PRE_LAST  = 6'(`MDIO_PREAMBLE_BITS - 1);
    localparam logic [5:0] LAST_BIT  = 6'(FRAME_BITS - 1);

    logic        busy_reg;
    logic [7:0]  prescale_reg;
    logic [5:0]  bit_cnt_reg;
    logic [31:0] shift_reg;
    logic        mdc_reg;
    logic        mdio_o_reg;
    logic        mdio_t_reg;

    // one frame in flight, bit n is on the wire while bit_cnt_reg is n
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            busy_reg     <= 1'b0;
            prescale_reg <= 8'd0;
            bit_cnt_reg  <= 6'd0;
            mdc_reg      <= 1'b0;
            mdio_o_reg   <= 1'b1;
            mdio_t_reg   <= 1'b1;
        end else if (!busy_reg) begin
            if (cmd_valid) begin
                // first preamble bit goes out with mdc low
                busy_reg     <= 1'b1;
                prescale_reg <= HALF_LOAD;
                bit_cnt_reg  <= 6'd0;
                mdio_o_reg   <= 1'b1;
                mdio_t_reg   <= 1'b0;
            end
        end else if (prescale_reg != 8'd0) begin
            prescale_reg <= prescale_reg - 8'd1;
        end else begin
            prescale_reg <= HALF_LOAD;
            if (!mdc_reg) begin
                // rising edge, PHY samples here
                mdc_reg <= 1'b1;
            end else begin
                mdc_reg <= 1'b0;
                if (bit_cnt_reg == LAST_BIT) begin
                    // end of frame, release the line
                    busy_reg   <= 1'b0;
                    mdio_o_reg <= 1'b1;
                    mdio_t_reg <= 1'b1;
                end else begin
                    bit_cnt_reg <= bit_cnt_reg + 6'd1;
                    if (bit_cnt_reg >= PRE_LAST) begin
                        mdio_o_reg <= shift_reg[31];
                    end else begin
                        mdio_o_reg <= 1'b1;
                    end
                end
            end
        end
    end

    // command bits, msb first once the preamble is out
    always_ff @(posedge clk_125mhz) begin
        if (!busy_reg && cmd_valid) begin
            shift_reg <= cmd.word;
        end else if (busy_reg && prescale_reg == 8'd0 && mdc_reg &&
                     bit_cnt_reg != LAST_BIT && bit_cnt_reg >= PRE_LAST) begin
            shift_reg <= {shift_reg[30:0], 1'b0};
        end
    end

    assign cmd_ready = !busy_reg;
    assign idle      = !busy_reg;
    assign mdc       = mdc_reg;
    assign mdio_o    = mdio_o_reg;
    assign mdio_t    = mdio_t_reg;

endmodule

// File: phy_init_fsm.sv
// start-up sequencer that writes the SGMII PHY extended registers through the MDIO master
`timescale 1ns/1ps
`include "phy_init_settings.svh"

module phy_init_fsm
    import phy_init_pkg::*;
(
    input  logic      clk_125mhz,
    input  logic      rst_125mhz,
    output logic      delay_start,
    input  logic      delay_expired,
    output mdio_cmd_t cmd,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    input  logic      master_idle,
    output logic      init_done
);

    localparam logic [1:0] ST_WAIT_DELAY = 2'd0;
    localparam logic [1:0] ST_ISSUE      = 2'd1;
    localparam logic [1:0] ST_WAIT_LAST  = 2'd2;
    localparam logic [1:0] ST_DONE       = 2'd3;

    // extended register access pair
    localparam logic [4:0] REG_REGCR = 5'h0D;
    localparam logic [4:0] REG_ADDAR = 5'h0E;

    localparam logic [3:0] LAST_STEP = 4'(`INIT_STEPS - 1);

    logic [1:0] state_reg;
    logic [3:0] step_reg;
    logic       start_reg;
    logic       cmd_valid_reg;
    mdio_cmd_t  cmd_reg;

    // four writes per extended register, step[3:2] picks the register
    function automatic mdio_cmd_t step_cmd(input logic [3:0] step);
        logic [15:0] target;
        logic [15:0] value;
        mdio_cmd_t   c;
        case (step[3:2])
            2'd0: begin
                // CFG4, SGMII autoneg timer 11 ms
                target = 16'h0031;
                value  = 16'h0070;
            end
            2'd1: begin
                // SGMIICTL1, SGMII clock output on
                target = 16'h00D3;
                value  = 16'h4000;
            end
            default: begin
                // 10M_SGMII_CFG, 10 Mbps over SGMII
                target = 16'h016F;
                value  = 16'h0015;
            end
        endcase
        case (step[1:0])
            2'd0:    c = mdio_write_cmd(REG_REGCR, 16'h001F);
            2'd1:    c = mdio_write_cmd(REG_ADDAR, target);
            2'd2:    c = mdio_write_cmd(REG_REGCR, 16'h401F);
            default: c = mdio_write_cmd(REG_ADDAR, value);
        endcase
        return c;
    endfunction

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state_reg     <= ST_WAIT_DELAY;
            step_reg      <= 4'd0;
            start_reg     <= 1'b1;
            cmd_valid_reg <= 1'b0;
        end else begin
            start_reg <= 1'b0;
            case (state_reg)
                ST_WAIT_DELAY: begin
                    if (delay_expired) begin
                        state_reg <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    // hold step and command until the master takes it
                    if (!cmd_valid_reg) begin
                        cmd_valid_reg <= 1'b1;
                    end else if (cmd_ready) begin
                        cmd_valid_reg <= 1'b0;
                        if (step_reg == LAST_STEP) begin
                            state_reg <= ST_WAIT_LAST;
                        end else begin
                            step_reg <= step_reg + 4'd1;
                        end
                    end
                end
                ST_WAIT_LAST: begin
                    // last frame still on the wire
                    if (master_idle) begin
                        state_reg <= ST_DONE;
                    end
                end
                default: begin
                    state_reg <= ST_DONE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (state_reg == ST_ISSUE && !cmd_valid_reg) begin
            cmd_reg <= step_cmd(step_reg);
        end
    end

    assign delay_start = start_reg;
    assign cmd         = cmd_reg;
    assign cmd_valid   = cmd_valid_reg;
    assign init_done   = (state_reg == ST_DONE);

endmodule

// File: init_delay_timer.sv
// power-up hold-off counter, loaded by the init sequencer and flagging when the delay is over
`timescale 1ns/1ps

module init_delay_timer (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,
    input  logic [19:0] load_value,
    input  logic        start,
    output logic        expired
);

    logic [19:0] count_reg;

    // the start cycle is the first cycle of the delay, hence the load of one less
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz || start) begin
            if (load_value == 20'd0) begin
                count_reg <= 20'd0;
            end else begin
                count_reg <= load_value - 20'd1;
            end
        end else if (count_reg != 20'd0) begin
            count_reg <= count_reg - 20'd1;
        end
    end

    // holds at zero until the next start
    assign expired = (count_reg == 20'd0) && !start;

endmodule

// File: phy_init_pkg.sv
// MDIO command word types and a clause-22 write builder for the sequencer, master and testbench
`include "phy_init_settings.svh"

package phy_init_pkg;

    // fixed clause-22 frame fields
    localparam logic [1:0] MDIO_ST_C22   = 2'b01;
    localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
    localparam logic [1:0] MDIO_TA       = 2'b10;

    // field layout, st is sent first
    typedef struct packed {
        logic [1:0]  st;
        logic [1:0]  op;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  ta;
        logic [15:0] data;
    } mdio_fields_t;

    // fields view for building, flat view for shifting out msb first
    typedef union packed {
        mdio_fields_t fields;
        logic [31:0]  word;
    } mdio_cmd_t;

    // write frame to the configured PHY
    function automatic mdio_cmd_t mdio_write_cmd(input logic [4:0] reg_addr,
                                                 input logic [15:0] data);
        mdio_cmd_t cmd;
        cmd.fields.st       = MDIO_ST_C22;
        cmd.fields.op       = MDIO_OP_WRITE;
        cmd.fields.phy_addr = `MDIO_PHY_ADDR;
        cmd.fields.reg_addr = reg_addr;
        cmd.fields.ta       = MDIO_TA;
        cmd.fields.data     = data;
        return cmd;
    endfunction

endpackage

// File: phy_init_settings.svh
// MDIO timing, PHY address and power-up delay constants, included by the package and the RTL
`ifndef PHY_INIT_SETTINGS_SVH
`define PHY_INIT_SETTINGS_SVH

// clk_125mhz cycles per MDC half period, 125 MHz / 6 gives about 20.8 MHz
`define MDC_HALF_PERIOD 3

// ones sent ahead of every command frame
`define MDIO_PREAMBLE_BITS 32

// strap address of the SGMII PHY
`define MDIO_PHY_ADDR 5'd3

// full hardware hold-off, about 8.4 ms at 125 MHz
`define INIT_DELAY_DEFAULT (2**20 - 1)

// write frames in the start-up sequence
`define INIT_STEPS 12

`endif
